// ==== Bender.yml ====
package:
  name: clock_rst_gen

sources:
  - design/clk_rst_pkg.sv
  - design/rst_sync.sv
  - design/clk_divider.sv
  - design/clk_rst_ctrl.sv
  - design/clock_rst_gen.sv
  - target: simulation
    files:
      - sim/tb_clock_rst_gen_assert.sv
      - sim/tb_clock_rst_gen.sv

// ==== filelist.f ====
design/clk_rst_pkg.sv
design/rst_sync.sv
design/clk_divider.sv
design/clk_rst_ctrl.sv
design/clock_rst_gen.sv
sim/tb_clock_rst_gen_assert.sv
sim/tb_clock_rst_gen.sv

// ==== sim/tb_clock_rst_gen.sv ====
`timescale 1ns/1ps

module tb_clock_rst_gen;

    localparam int SYNC_STAGES  = 2;
    localparam int INIT_SOC     = 1;
    localparam int INIT_CLUSTER = 1;
    localparam int INIT_OUT     = 10;
    localparam int TIMEOUT      = 100;  // Cycles allowed per wait

    logic                      clk;
    logic                      rst_n;
    logic                      test_mode;
    logic [1:0]                inhibit;    // Soc, cluster
    logic [1:0]                sw_rstn;    // Soc, cluster
    logic [2:0]                en;         // Soc, cluster, clock out
    logic [2:0]                valid;
    clk_rst_pkg::div_t         data [3];
    clk_rst_pkg::clk_out_sel_e sel;
    wire  [2:0]                ack;
    wire  [2:0]                clk_div;    // Soc, cluster, pad clock
    wire  [2:0]                rstn_sync;  // Ref, soc, cluster
    wire                       rstn_cluster;

    int         seed = 22;
    int         errors = 0;
    int         timeouts = 0;
    int         exp_ratio [3];  // Model ratio per divider
    logic [2:0] exp_req;        // Model requests, same order as rstn_sync
    int         hi_cnt [3];     // Edges seen with each request high

    clock_rst_gen #(
        .SYNC_STAGES      (SYNC_STAGES),
        .DIV_INIT_SOC     (INIT_SOC),
        .DIV_INIT_CLUSTER (INIT_CLUSTER),
        .DIV_INIT_OUT     (INIT_OUT)
    ) uut (
        .ref_clk_i                  (clk),
        .rst_n_i                    (rst_n),
        .test_mode_i                (test_mode),
        .jtag_soc_rst_inhibit_i     (inhibit[0]),
        .jtag_cluster_rst_inhibit_i (inhibit[1]),
        .pm_soc_sw_rstn_i           (sw_rstn[0]),
        .pm_cluster_sw_rstn_i       (sw_rstn[1]),
        .pm_enable_soc_clk_i        (en[0]),
        .pm_enable_cluster_clk_i    (en[1]),
        .jtag_enable_clk_out_i      (en[2]),
        .jtag_clk_out_sel_i         (sel),
        .clk_div0_data_i            (data[0]),
        .clk_div0_valid_i           (valid[0]),
        .clk_div0_ack_o             (ack[0]),
        .clk_div1_data_i            (data[1]),
        .clk_div1_valid_i           (valid[1]),
        .clk_div1_ack_o             (ack[1]),
        .clk_div2_data_i            (data[2]),
        .clk_div2_valid_i           (valid[2]),
        .clk_div2_ack_o             (ack[2]),
        .clk_soc_o                  (clk_div[0]),
        .clk_cluster_o              (clk_div[1]),
        .clk_out_o                  (clk_div[2]),
        .rstn_sync_ref_o            (rstn_sync[0]),
        .rstn_sync_o                (rstn_sync[1]),
        .rstn_cluster_o             (rstn_cluster),
        .rstn_cluster_sync_o        (rstn_sync[2])
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns reference period
    end

    task automatic check_eq(input integer actual, input integer expected, input string msg);
        if (actual !== expected)
        begin
            $display("CHECK FAILED at %0t ns: %s (got %0d, expected %0d)",
                     $time, msg, actual, expected);
            errors++;
        end
    endtask

    // Drive and sample point, 1 ns past the edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // 0..2 clocks, 3..5 synced resets, 6..8 acks
    function automatic logic probe(input int idx);
        if (idx < 3)
            return clk_div[idx];
        else if (idx < 6)
            return rstn_sync[idx-3];
        return ack[idx-6];
    endfunction

    // Cycles until the probed signal is high
    task automatic wait_high(input int idx, output int cycles);
        cycles = 0;
        do
        begin
            tick();
            cycles++;
        end
        while (!probe(idx) && cycles < TIMEOUT);
        if (!probe(idx))
        begin
            $display("Timeout at %0t ns: signal %0d never went high", $time, idx);
            timeouts++;
            cycles = -1;
        end
    endtask

    // Cycles until the next rising edge of a clock
    task automatic wait_rise(input int idx, output int cycles);
        logic prev;
        logic now;
        cycles = 0;
        now = probe(idx);
        do
        begin
            prev = now;
            tick();
            now = probe(idx);
            cycles++;
        end
        while (!(now && !prev) && cycles < TIMEOUT);
        if (!(now && !prev))
        begin
            $display("Timeout at %0t ns: clock %0d has no rising edge", $time, idx);
            timeouts++;
            cycles = -1;
        end
    endtask

    task automatic check_period(input int idx, input int src, input string msg);
        int cycles;
        wait_rise(idx, cycles);  // May close a half-period of the old ratio
        wait_rise(idx, cycles);
        wait_rise(idx, cycles);  // Clean period at the new ratio
        check_eq(cycles, 2 * exp_ratio[src], msg);
    endtask

    task automatic configure(input int n, input int ratio);
        int cycles;
        data[n]  = clk_rst_pkg::div_t'(ratio);
        valid[n] = 1'b1;
        wait_high(6 + n, cycles);
        check_eq(cycles, 1, "ack latency");
        tick();  // Valid still high on this edge
        check_eq(ack[n], 0, "ack longer than one cycle");
        valid[n]     = 1'b0;  // Released the cycle after ack
        exp_ratio[n] = ratio;
    endtask

    // Test mode passes the pad reset, software reset wins otherwise
    function automatic logic req_model(input logic inh, input logic sw);
        if (test_mode)
            return rst_n;
        if (!sw)
            return 1'b0;
        return rst_n || inh;
    endfunction

    // Synced output rises once its request was high for SYNC_STAGES edges
    task automatic check_resets(input bit edge_seen);
        int i;
        exp_req = {req_model(inhibit[1], sw_rstn[1]), req_model(inhibit[0], sw_rstn[0]), rst_n};
        for (i = 0; i < 3; i++)
        begin
            if (!exp_req[i])
                hi_cnt[i] = 0;
            else if (edge_seen && hi_cnt[i] < SYNC_STAGES)
                hi_cnt[i]++;
            check_eq(rstn_sync[i], hi_cnt[i] >= SYNC_STAGES, "synchronized reset");
        end
        check_eq(rstn_cluster, exp_req[2], "raw cluster request");
    endtask

    initial
    begin
        int cycles;
        int n;
        int k;
        logic prev;
        rst_n     = 1'b0;
        test_mode = 1'b0;
        inhibit   = 2'b00;
        sw_rstn   = 2'b11;
        en        = 3'b111;
        valid     = 3'b000;
        data      = '{default: '0};
        sel       = clk_rst_pkg::SEL_OUT_DIV;
        exp_ratio = '{INIT_SOC, INIT_CLUSTER, INIT_OUT};

        // Everything quiet while in reset
        repeat (5)
        begin
            tick();
            check_eq({ack, clk_div, rstn_sync}, 0, "outputs in reset");
        end
        rst_n = 1'b1;
        check_eq({ack, clk_div, rstn_sync}, 0, "outputs at release");
        wait_high(3, cycles);
        check_eq(cycles, SYNC_STAGES, "ref reset release latency");
        hi_cnt = '{SYNC_STAGES, SYNC_STAGES, SYNC_STAGES};

        // Random ratios on all three dividers
        repeat (3)
        begin
            for (n = 0; n < 3; n++)
            begin
                configure(n, 1 + ($unsigned($random(seed)) % 12));
                check_period(n, n, "divided clock period");
            end
        end

        // Test mode holds off a pending request with a new ratio
        n = $unsigned($random(seed)) % 3;
        test_mode = 1'b1;
        data[n]   = clk_rst_pkg::div_t'(1 + ((exp_ratio[n] + $unsigned($random(seed)) % 11) % 12));
        valid[n]  = 1'b1;
        repeat (TIMEOUT)
        begin
            tick();
            check_eq(ack[n], 0, "ack in test mode");
        end
        check_period(n, n, "period kept in test mode");
        test_mode = 1'b0;
        configure(n, data[n]);  // Held request goes through once test mode ends
        check_period(n, n, "period after test mode");

        // Random request inputs, pad pulse every fourth step, defaults last
        for (k = 0; k < 13; k++)
        begin
            inhibit   = (k < 12) ? 2'($random(seed)) : 2'b00;
            sw_rstn   = (k < 12) ? 2'($random(seed)) : 2'b11;
            test_mode = (k < 12) ? 1'($random(seed)) : 1'b0;
            rst_n     = (k % 4 != 3);
            #1;
            check_resets(1'b0);  // Falls show up without an edge
            repeat (SYNC_STAGES + 1)
            begin
                tick();
                check_resets(1'b1);
            end
            if (!rst_n)
                exp_ratio = '{INIT_SOC, INIT_CLUSTER, INIT_OUT};  // Dividers reset too
        end

        // Disabled clock stays quiet for a window
        for (n = 0; n < 3; n++)
        begin
            en[n] = 1'b0;
            tick();
            tick();  // Pad clock lags one more cycle
            prev = probe(n);
            repeat (40)
            begin
                tick();
                check_eq(!prev && probe(n), 0, "edge on disabled clock");
                prev = probe(n);
            end
            en[n] = 1'b1;
        end

        // Codes 2 and 3 both pick the clock-out divider
        for (k = 0; k < 4; k++)
        begin
            sel = clk_rst_pkg::clk_out_sel_e'(k);
            check_period(2, (k < 2) ? k : 2, "clock-out select period");
        end

        check_eq(uut.u_assert.fail_count, 0, "assertion failures");
        $display("Errors: %0d check, %0d timeout", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// ==== sim/tb_clock_rst_gen_assert.sv ====
`timescale 1ns/1ps

// Handshake checks on the port side of clock_rst_gen
module tb_clock_rst_gen_assert (
    input logic       ref_clk_i,
    input logic       rst_n_i,
    input logic       test_mode_i,
    input logic [2:0] valid_i,   // One bit per divider
    input logic [2:0] ack_i
);

    int fail_count = 0;  // Read back at the end of the run

    // Single-cycle ack pulse
    ack_one_cycle: assert property (@(posedge ref_clk_i) disable iff (!rst_n_i)
        (ack_i & $past(ack_i)) == 3'b000)
    else
    begin
        $error("ack high for more than one cycle");
        fail_count++;
    end

    // Every ack answers a valid seen one edge earlier
    ack_after_valid: assert property (@(posedge ref_clk_i) disable iff (!rst_n_i)
        (ack_i & ~$past(valid_i)) == 3'b000)
    else
    begin
        $error("ack without valid in the previous cycle");
        fail_count++;
    end

    // Valid is blocked in test mode, so the next edge brings no ack
    ack_masked_in_test: assert property (@(posedge ref_clk_i) disable iff (!rst_n_i)
        $past(test_mode_i) |-> (ack_i == 3'b000))
    else
    begin
        $error("ack seen while in test mode");
        fail_count++;
    end

endmodule

bind clock_rst_gen tb_clock_rst_gen_assert u_assert (
    .ref_clk_i   (ref_clk_i),
    .rst_n_i     (rst_n_i),
    .test_mode_i (test_mode_i),
    .valid_i     ({clk_div2_valid_i, clk_div1_valid_i, clk_div0_valid_i}),
    .ack_i       ({clk_div2_ack_o, clk_div1_ack_o, clk_div0_ack_o})
);

// ==== design/clock_rst_gen.sv ====
`timescale 1ns/1ps

// Clock and reset generator for the soc and cluster domains
module clock_rst_gen #(
    parameter int                SYNC_STAGES      = clk_rst_pkg::SYNC_STAGES_DEF,
    parameter clk_rst_pkg::div_t DIV_INIT_SOC     = clk_rst_pkg::DIV_INIT_SOC,
    parameter clk_rst_pkg::div_t DIV_INIT_CLUSTER = clk_rst_pkg::DIV_INIT_CLUSTER,
    parameter clk_rst_pkg::div_t DIV_INIT_OUT     = clk_rst_pkg::DIV_INIT_OUT
) (
    input  logic                      ref_clk_i,
    input  logic                      rst_n_i,
    input  logic                      test_mode_i,

    input  logic                      jtag_soc_rst_inhibit_i,
    input  logic                      jtag_cluster_rst_inhibit_i,
    input  logic                      pm_soc_sw_rstn_i,
    input  logic                      pm_cluster_sw_rstn_i,

    input  logic                      pm_enable_soc_clk_i,
    input  logic                      pm_enable_cluster_clk_i,
    input  logic                      jtag_enable_clk_out_i,
    input  clk_rst_pkg::clk_out_sel_e jtag_clk_out_sel_i,

    input  clk_rst_pkg::div_t         clk_div0_data_i,   // Soc
    input  logic                      clk_div0_valid_i,
    output logic                      clk_div0_ack_o,
    input  clk_rst_pkg::div_t         clk_div1_data_i,   // Cluster
    input  logic                      clk_div1_valid_i,
    output logic                      clk_div1_ack_o,
    input  clk_rst_pkg::div_t         clk_div2_data_i,   // Clock out
    input  logic                      clk_div2_valid_i,
    output logic                      clk_div2_ack_o,

    output logic                      clk_soc_o,
    output logic                      clk_cluster_o,
    output logic                      clk_out_o,
    output logic                      rstn_sync_ref_o,      // Pad reset in ref domain
    output logic                      rstn_sync_o,          // Soc reset
    output logic                      rstn_cluster_o,       // Raw cluster request
    output logic                      rstn_cluster_sync_o
);

    logic [2:0] ext_valid;    // Valid as seen on the ports
    logic [2:0] ext_ack;
    logic [2:0] div_valid;    // After test-mode masking
    logic [2:0] div_ack;
    logic       rstn_soc_req;
    logic       rstn_cluster_req;
    logic       clk_out_div;  // Before the output select

    assign ext_valid = {clk_div2_valid_i, clk_div1_valid_i, clk_div0_valid_i};

    assign clk_div0_ack_o = ext_ack[0];
    assign clk_div1_ack_o = ext_ack[1];
    assign clk_div2_ack_o = ext_ack[2];

    clk_rst_ctrl u_ctrl (
        .ref_clk_i                  (ref_clk_i),
        .rst_n_i                    (rst_n_i),
        .test_mode_i                (test_mode_i),
        .jtag_soc_rst_inhibit_i     (jtag_soc_rst_inhibit_i),
        .jtag_cluster_rst_inhibit_i (jtag_cluster_rst_inhibit_i),
        .pm_soc_sw_rstn_i           (pm_soc_sw_rstn_i),
        .pm_cluster_sw_rstn_i       (pm_cluster_sw_rstn_i),
        .jtag_clk_out_sel_i         (jtag_clk_out_sel_i),
        .ext_valid_i                (ext_valid),
        .ext_ack_o                  (ext_ack),
        .div_valid_o                (div_valid),
        .div_ack_i                  (div_ack),
        .clk_soc_i                  (clk_soc_o),
        .clk_cluster_i              (clk_cluster_o),
        .clk_out_div_i              (clk_out_div),
        .rstn_soc_req_o             (rstn_soc_req),
        .rstn_cluster_req_o         (rstn_cluster_req),
        .clk_out_o                  (clk_out_o)
    );

    // Dividers all run off the pad reset
    clk_divider #(.DIV_INIT(DIV_INIT_SOC)) u_div_soc (
        .ref_clk_i   (ref_clk_i),
        .rst_n_i     (rst_n_i),
        .en_i        (pm_enable_soc_clk_i),
        .div_data_i  (clk_div0_data_i),
        .div_valid_i (div_valid[0]),
        .div_ack_o   (div_ack[0]),
        .clk_o       (clk_soc_o)
    );

    clk_divider #(.DIV_INIT(DIV_INIT_CLUSTER)) u_div_cluster (
        .ref_clk_i   (ref_clk_i),
        .rst_n_i     (rst_n_i),
        .en_i        (pm_enable_cluster_clk_i),
        .div_data_i  (clk_div1_data_i),
        .div_valid_i (div_valid[1]),
        .div_ack_o   (div_ack[1]),
        .clk_o       (clk_cluster_o)
    );

    clk_divider #(.DIV_INIT(DIV_INIT_OUT)) u_div_out (
        .ref_clk_i   (ref_clk_i),
        .rst_n_i     (rst_n_i),
        .en_i        (jtag_enable_clk_out_i),
        .div_data_i  (clk_div2_data_i),
        .div_valid_i (div_valid[2]),
        .div_ack_o   (div_ack[2]),
        .clk_o       (clk_out_div)
    );

    rst_sync #(.SYNC_STAGES(SYNC_STAGES)) u_sync_ref (
        .ref_clk_i (ref_clk_i),
        .rst_n_i   (rst_n_i),
        .rst_n_o   (rstn_sync_ref_o)
    );

    rst_sync #(.SYNC_STAGES(SYNC_STAGES)) u_sync_soc (
        .ref_clk_i (ref_clk_i),
        .rst_n_i   (rstn_soc_req),
        .rst_n_o   (rstn_sync_o)
    );

    rst_sync #(.SYNC_STAGES(SYNC_STAGES)) u_sync_cluster (
        .ref_clk_i (ref_clk_i),
        .rst_n_i   (rstn_cluster_req),
        .rst_n_o   (rstn_cluster_sync_o)
    );

    assign rstn_cluster_o = rstn_cluster_req;  // Unsynchronized copy

endmodule

// ==== design/clk_rst_ctrl.sv ====
`timescale 1ns/1ps

// Test-mode handling, reset requests and clock-out selection
module clk_rst_ctrl (
    input  logic                      ref_clk_i,
    input  logic                      rst_n_i,       // Pad reset
    input  logic                      test_mode_i,

    input  logic                      jtag_soc_rst_inhibit_i,      // Debug holds soc out of reset
    input  logic                      jtag_cluster_rst_inhibit_i,  // Same for cluster
    input  logic                      pm_soc_sw_rstn_i,            // PM software reset of soc
    input  logic                      pm_cluster_sw_rstn_i,        // PM software reset of cluster

    input  clk_rst_pkg::clk_out_sel_e jtag_clk_out_sel_i,

    input  logic [2:0]                ext_valid_i,   // From the requesters
    output logic [2:0]                ext_ack_o,
    output logic [2:0]                div_valid_o,   // To the dividers
    input  logic [2:0]                div_ack_i,

    input  logic                      clk_soc_i,
    input  logic                      clk_cluster_i,
    input  logic                      clk_out_div_i,

    output logic                      rstn_soc_req_o,
    output logic                      rstn_cluster_req_o,
    output logic                      clk_out_o
);

    logic clk_out_mux;  // Chosen source before the output flop
    logic clk_out_q;

    // Test mode leaves only the pad reset
    // Inhibit overrides the pad, software reset overrides both
    assign rstn_soc_req_o = test_mode_i ? rst_n_i :
                            (rst_n_i | jtag_soc_rst_inhibit_i) & pm_soc_sw_rstn_i;
    assign rstn_cluster_req_o = test_mode_i ? rst_n_i :
                                (rst_n_i | jtag_cluster_rst_inhibit_i) & pm_cluster_sw_rstn_i;

    // No configuration traffic while in test
    assign div_valid_o = test_mode_i ? 3'b000 : ext_valid_i;
    assign ext_ack_o   = test_mode_i ? 3'b000 : div_ack_i;

    always_comb
    begin
        case (jtag_clk_out_sel_i)
            clk_rst_pkg::SEL_SOC:     clk_out_mux = clk_soc_i;
            clk_rst_pkg::SEL_CLUSTER: clk_out_mux = clk_cluster_i;
            default:                  clk_out_mux = clk_out_div_i;  // Codes 2 and 3
        endcase
    end

    // Pad clock lags its source by one ref cycle
    always_ff @(posedge ref_clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
            clk_out_q <= 1'b0;
        else
            clk_out_q <= clk_out_mux;
    end

    assign clk_out_o = clk_out_q;

endmodule

// ==== design/clk_divider.sv ====
`timescale 1ns/1ps

// Programmable divider running on ref_clk_i
// Output is a plain flop toggled every ratio cycles
module clk_divider #(
    parameter clk_rst_pkg::div_t DIV_INIT = clk_rst_pkg::div_t'(1)
) (
    input  logic              ref_clk_i,
    input  logic              rst_n_i,
    input  logic              en_i,         // Clock enable from PM or debug
    input  clk_rst_pkg::div_t div_data_i,   // New half-period
    input  logic              div_valid_i,
    output logic              div_ack_o,    // One-cycle pulse per accepted ratio
    output logic              clk_o
);

    logic              ack_q;
    logic              cfg_take;   // Accept this cycle
    logic              cnt_end;    // Half-period finished
    logic              clk_q;
    clk_rst_pkg::div_t ratio_q;    // Current half-period
    clk_rst_pkg::div_t ratio_eff;  // Ratio with zero mapped to one
    clk_rst_pkg::div_t cnt_q;      // Cycles left in this half-period

    // A held valid right after its ack is the same request
    assign cfg_take = div_valid_i & ~ack_q;

    assign ratio_eff = (ratio_q == '0) ? clk_rst_pkg::div_t'(1) : ratio_q;
    assign cnt_end   = (cnt_q <= clk_rst_pkg::div_t'(1));  // Also true after reset

    // Configuration side of the handshake
    always_ff @(posedge ref_clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            ack_q   <= 1'b0;
            ratio_q <= DIV_INIT;
        end
        else
        begin
            ack_q <= cfg_take;  // Ack one cycle after valid
            if (cfg_take)
            begin
                ratio_q <= div_data_i;  // Used from the next reload on
            end
        end
    end

    // Half-period counter and output toggle
    always_ff @(posedge ref_clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            cnt_q <= '0;
            clk_q <= 1'b0;
        end
        else if (!en_i)
        begin
            // Count frozen, clock parked low
            clk_q <= 1'b0;
        end
        else if (cnt_end)
        begin
            cnt_q <= ratio_eff;  // Reload picks up any new ratio here
            clk_q <= ~clk_q;
        end
        else
        begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    assign div_ack_o = ack_q;
    assign clk_o     = clk_q;

endmodule

// ==== design/rst_sync.sv ====
`timescale 1ns/1ps

// Asynchronous assert, synchronous release of one reset
module rst_sync #(
    parameter int SYNC_STAGES = clk_rst_pkg::SYNC_STAGES_DEF
) (
    input  logic ref_clk_i,
    input  logic rst_n_i,   // Request to synchronize, active low
    output logic rst_n_o
);

    // Chain of ones shifted in from the bottom
    logic [SYNC_STAGES-1:0] sync_q;

    always_ff @(posedge ref_clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            sync_q <= '0;  // Output drops at once
        end
        else
        begin
            // One more stage released per edge
            sync_q <= (sync_q << 1) | SYNC_STAGES'(1);
        end
    end

    // Top stage only
    // Released on the SYNC_STAGES-th edge
    assign rst_n_o = sync_q[SYNC_STAGES-1];

endmodule

// ==== design/clk_rst_pkg.sv ====
package clk_rst_pkg;

    // Width of one division ratio
    localparam int DIV_W = 8;

    // Half-period of a divided clock in ref_clk_i cycles
    // Zero is treated as one by the divider
    typedef logic [DIV_W-1:0] div_t;

    // Source of the clock-out pin
    // Code 3 also picks the clock-out divider
    typedef enum logic [1:0] {
        SEL_SOC     = 2'd0,  // Soc divided clock
        SEL_CLUSTER = 2'd1,  // Cluster divided clock
        SEL_OUT_DIV = 2'd2   // Dedicated clock-out divider
    } clk_out_sel_e;

    // Flops in each reset synchronizer
    localparam int SYNC_STAGES_DEF = 2;

    // Ratios loaded at reset
    localparam div_t DIV_INIT_SOC     = 8'd1;
    localparam div_t DIV_INIT_CLUSTER = 8'd1;
    localparam div_t DIV_INIT_OUT     = 8'd10;  // Slow pad clock by default

endpackage
